//--- include/cpu_params.svh
// word width, register count and reset pc for the pipelined cpu
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data and address width
`define CPU_WORD_W 32

// architectural registers, r0 hardwired to zero
`define CPU_REG_COUNT 32

// first fetch address out of reset
`define CPU_PC_INIT 32'h0000_0000

`endif

//--- logic/cpu_types_pkg.sv
// cpu types: words, opcodes, alu ops, instruction union, latch and memory port structs
`include "cpu_params.svh"

package cpu_types_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;
  typedef logic [4:0] regsel_t;

  // opcodes of the supported subset
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    BEQ   = 6'b000100,
    ADDIU = 6'b001001,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_e;

  // r-type function field
  typedef enum logic [5:0] {
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    SLT  = 6'b101010
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } aluop_e;

  typedef struct packed {
    opcode_e    opcode;
    regsel_t    rs;
    regsel_t    rt;
    regsel_t    rd;
    logic [4:0] shamt;
    funct_e     funct;
  } r_t;

  typedef struct packed {
    opcode_e     opcode;
    regsel_t     rs;
    regsel_t     rt;
    logic [15:0] imm;
  } i_t;

  // same fetched word, seen as r-type or i-type
  typedef union packed {
    r_t r;
    i_t i;
  } instr_t;

  // fetch/decode latch
  typedef struct packed {
    logic   valid;
    word_t  pc;
    instr_t instr;
  } fd_t;

  // decode/execute latch
  typedef struct packed {
    logic    valid;
    regsel_t rs;
    regsel_t rt;
    regsel_t wsel;
    word_t   rdat1;
    word_t   rdat2;
    word_t   imm;
    aluop_e  aluop;
    logic    alusrc;
    logic    memrd;
    logic    memwr;
    logic    regwr;
    logic    branch;
    logic    halt;
    word_t   pc;
  } de_t;

  // execute/memory latch
  typedef struct packed {
    logic    valid;
    word_t   aluout;
    word_t   store;
    regsel_t wsel;
    logic    memrd;
    logic    memwr;
    logic    regwr;
    logic    halt;
  } em_t;

  // memory/writeback latch
  typedef struct packed {
    logic    valid;
    word_t   aluout;
    word_t   dmemload;
    regsel_t wsel;
    logic    memtoreg;
    logic    regwr;
    logic    halt;
  } mw_t;

  // datapath to memory
  typedef struct packed {
    word_t imemaddr;
    logic  dmemREN;
    logic  dmemWEN;
    word_t dmemaddr;
    word_t dmemstore;
  } dp_req_t;

  // memory to datapath
  typedef struct packed {
    logic  ihit;
    word_t imemload;
    logic  dhit;
    word_t dmemload;
  } cache_rsp_t;

endpackage

//--- logic/register_file.sv
// register file with two read ports, write bypass and r0 tied to zero
`timescale 1ns/1ps
`include "cpu_params.svh"

module register_file (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  wen,
  input  cpu_types_pkg::regsel_t wsel,
  input  cpu_types_pkg::word_t   wdat,
  input  cpu_types_pkg::regsel_t rsel1,
  input  cpu_types_pkg::regsel_t rsel2,
  output cpu_types_pkg::word_t   rdat1,
  output cpu_types_pkg::word_t   rdat2
);
  cpu_types_pkg::word_t regs [`CPU_REG_COUNT];

  // r0 never written
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      regs <= '{default: '0};
    end
    else if (wen && wsel != '0)
    begin
      regs[wsel] <= wdat;
    end
  end

  // one read port, same-cycle write wins
  function automatic cpu_types_pkg::word_t read_port(cpu_types_pkg::regsel_t rsel);
    if (rsel == '0)
      return '0;
    if (wen && rsel == wsel)
      return wdat;
    return regs[rsel];
  endfunction

  always_comb
  begin
    rdat1 = read_port(rsel1);
    rdat2 = read_port(rsel2);
  end

endmodule

//--- logic/decode_stage.sv
// decode stage: control decode, register read and immediate sign extension
`timescale 1ns/1ps
`include "cpu_params.svh"

module decode_stage (
  input  logic                   CLK,
  input  logic                   nRST,
  input  cpu_types_pkg::fd_t     fd,
  input  logic                   wb_regwr,
  input  cpu_types_pkg::regsel_t wb_wsel,
  input  cpu_types_pkg::word_t   wb_wdat,
  output cpu_types_pkg::de_t     de
);
  cpu_types_pkg::word_t rdat1;
  cpu_types_pkg::word_t rdat2;

  // rs and rt sit in the same bits for both formats
  register_file rf0 (
    .CLK   (CLK),
    .nRST  (nRST),
    .wen   (wb_regwr),
    .wsel  (wb_wsel),
    .wdat  (wb_wdat),
    .rsel1 (fd.instr.r.rs),
    .rsel2 (fd.instr.r.rt),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  always_comb
  begin
    de = '0;
    de.valid = fd.valid;
    de.pc = fd.pc;
    de.rs = fd.instr.r.rs;
    de.rt = fd.instr.r.rt;
    de.rdat1 = rdat1;
    de.rdat2 = rdat2;
    // sign extend
    de.imm = {{(`CPU_WORD_W-16){fd.instr.i.imm[15]}}, fd.instr.i.imm};
    de.aluop = cpu_types_pkg::ALU_ADD;
    case (fd.instr.r.opcode)
      cpu_types_pkg::RTYPE:
      begin
        de.wsel = fd.instr.r.rd;
        de.regwr = 1'b1;
        case (fd.instr.r.funct)
          cpu_types_pkg::ADDU: de.aluop = cpu_types_pkg::ALU_ADD;
          cpu_types_pkg::SUBU: de.aluop = cpu_types_pkg::ALU_SUB;
          cpu_types_pkg::AND:  de.aluop = cpu_types_pkg::ALU_AND;
          cpu_types_pkg::OR:   de.aluop = cpu_types_pkg::ALU_OR;
          cpu_types_pkg::SLT:  de.aluop = cpu_types_pkg::ALU_SLT;
          default:             de.valid = 1'b0;
        endcase
      end
      cpu_types_pkg::ADDIU:
      begin
        de.wsel = fd.instr.i.rt;
        de.alusrc = 1'b1;
        de.regwr = 1'b1;
      end
      cpu_types_pkg::LW:
      begin
        de.wsel = fd.instr.i.rt;
        de.alusrc = 1'b1;
        de.memrd = 1'b1;
        de.regwr = 1'b1;
      end
      cpu_types_pkg::SW:
      begin
        de.alusrc = 1'b1;
        de.memwr = 1'b1;
      end
      // compare done in execute on forwarded operands
      cpu_types_pkg::BEQ:
      begin
        de.branch = 1'b1;
        de.aluop = cpu_types_pkg::ALU_SUB;
      end
      cpu_types_pkg::HALT: de.halt = 1'b1;
      default:             de.valid = 1'b0;
    endcase
    // bubbles and unknown opcodes carry no side effects
    if (!de.valid)
    begin
      de.regwr = 1'b0;
      de.memrd = 1'b0;
      de.memwr = 1'b0;
      de.branch = 1'b0;
      de.halt = 1'b0;
    end
  end

endmodule

//--- logic/exec_stage.sv
// execute stage: operand select, alu and beq resolution
`timescale 1ns/1ps

module exec_stage (
  input  cpu_types_pkg::de_t   de,
  input  cpu_types_pkg::word_t opa,
  input  cpu_types_pkg::word_t opb,
  output cpu_types_pkg::em_t   em,
  output logic                 branch_taken,
  output cpu_types_pkg::word_t branch_target
);
  cpu_types_pkg::word_t alu_b;
  cpu_types_pkg::word_t alu_out;

  // immediate for i-type, forwarded rt otherwise
  assign alu_b = de.alusrc ? de.imm : opb;

  always_comb
  begin
    case (de.aluop)
      cpu_types_pkg::ALU_SUB: alu_out = opa - alu_b;
      cpu_types_pkg::ALU_AND: alu_out = opa & alu_b;
      cpu_types_pkg::ALU_OR:  alu_out = opa | alu_b;
      // signed compare
      cpu_types_pkg::ALU_SLT: alu_out = cpu_types_pkg::word_t'($signed(opa) < $signed(alu_b));
      default:                alu_out = opa + alu_b;
    endcase
  end

  // beq taken on equal operands
  assign branch_taken = de.valid && de.branch && (opa == opb);
  // pc+4 plus word offset
  assign branch_target = de.pc + 4 + (de.imm << 2);

  always_comb
  begin
    em.valid = de.valid;
    em.aluout = alu_out;
    // store data is the forwarded rt
    em.store = opb;
    em.wsel = de.wsel;
    em.memrd = de.memrd;
    em.memwr = de.memwr;
    em.regwr = de.regwr;
    em.halt = de.halt;
  end

endmodule

//--- logic/forwarding_unit.sv
// forwarding mux for both execute operands from the memory and writeback stages
`timescale 1ns/1ps

module forwarding_unit (
  input  cpu_types_pkg::de_t   de,
  input  cpu_types_pkg::em_t   em,
  input  cpu_types_pkg::mw_t   mw,
  input  cpu_types_pkg::word_t wb_wdat,
  output cpu_types_pkg::word_t opa,
  output cpu_types_pkg::word_t opb
);

  // youngest producer first, r0 always from the file
  function automatic cpu_types_pkg::word_t pick(
    cpu_types_pkg::regsel_t src,
    cpu_types_pkg::word_t   rf_val
  );
    if (src == '0)
      return rf_val;
    // memory stage result
    if (em.valid && em.regwr && em.wsel == src)
      return em.aluout;
    // writeback value, load data included
    if (mw.valid && mw.regwr && mw.wsel == src)
      return wb_wdat;
    return rf_val;
  endfunction

  always_comb
  begin
    opa = pick(de.rs, de.rdat1);
    opb = pick(de.rt, de.rdat2);
  end

endmodule

//--- logic/hazard_unit.sv
// load-use stall detection and branch flush control
`timescale 1ns/1ps

module hazard_unit (
  input  cpu_types_pkg::fd_t fd,
  input  cpu_types_pkg::de_t de,
  input  logic               branch_taken,
  output logic               stall,
  output logic               flush
);
  logic load_in_ex;

  // load in execute, data only ready in writeback
  assign load_in_ex = de.valid && de.memrd && de.wsel != '0;

  // rs and rt sit in the same bits for both formats
  assign stall = load_in_ex && fd.valid
    && (fd.instr.r.rs == de.wsel || fd.instr.r.rt == de.wsel);

  // taken beq drops the fetch and decode slots
  assign flush = branch_taken;

  // flush only from a valid beq in execute
  always_comb
  begin
    a_flush_beq: assert final (!flush || (de.valid && de.branch))
      else $error("branch flush without a valid beq in execute");
  end

endmodule

//--- logic/datapath.sv
// pipeline top: pc, stage latches, data port, writeback select and sticky halt
`timescale 1ns/1ps
`include "cpu_params.svh"

module datapath (
  input  logic                      CLK,
  input  logic                      nRST,
  input  cpu_types_pkg::cache_rsp_t rsp,
  output cpu_types_pkg::dp_req_t    req,
  output logic                      halt
);
  cpu_types_pkg::word_t pc;
  cpu_types_pkg::fd_t   fd_q;
  cpu_types_pkg::fd_t   fd_d;
  cpu_types_pkg::de_t   de_q;
  cpu_types_pkg::de_t   de_d;
  cpu_types_pkg::em_t   em_q;
  cpu_types_pkg::em_t   em_d;
  cpu_types_pkg::mw_t   mw_q;
  cpu_types_pkg::mw_t   mw_d;
  cpu_types_pkg::word_t opa;
  cpu_types_pkg::word_t opb;
  cpu_types_pkg::word_t wb_wdat;
  cpu_types_pkg::word_t branch_target;
  logic                 wb_regwr;
  logic                 branch_taken;
  logic                 stall;
  logic                 flush;
  logic                 mem_wait;
  logic                 fetch_freeze;
  logic                 fetch_ok;

  decode_stage dec0 (
    .CLK      (CLK),
    .nRST     (nRST),
    .fd       (fd_q),
    .wb_regwr (wb_regwr),
    .wb_wsel  (mw_q.wsel),
    .wb_wdat  (wb_wdat),
    .de       (de_d)
  );

  exec_stage ex0 (
    .de            (de_q),
    .opa           (opa),
    .opb           (opb),
    .em            (em_d),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  forwarding_unit fwd0 (
    .de      (de_q),
    .em      (em_q),
    .mw      (mw_q),
    .wb_wdat (wb_wdat),
    .opa     (opa),
    .opb     (opb)
  );

  hazard_unit haz0 (
    .fd           (fd_q),
    .de           (de_q),
    .branch_taken (branch_taken),
    .stall        (stall),
    .flush        (flush)
  );

  // fetch always requested, data port driven from the memory latch
  always_comb
  begin
    req.imemaddr = pc;
    req.dmemREN = em_q.valid && em_q.memrd;
    req.dmemWEN = em_q.valid && em_q.memwr;
    req.dmemaddr = em_q.aluout;
    req.dmemstore = em_q.store;
  end

  // pending data access holds the whole pipe
  assign mem_wait = (req.dmemREN || req.dmemWEN) && !rsp.dhit;

  // no fetch past a halt anywhere in flight
  assign fetch_freeze = halt
    || (de_d.valid && de_d.halt)
    || (de_q.valid && de_q.halt)
    || (em_q.valid && em_q.halt)
    || (mw_q.valid && mw_q.halt);
  assign fetch_ok = rsp.ihit && !fetch_freeze;

  // miss or freeze sends a bubble
  always_comb
  begin
    fd_d.valid = fetch_ok;
    fd_d.pc = pc;
    fd_d.instr = rsp.imemload;
  end

  always_comb
  begin
    mw_d.valid = em_q.valid;
    mw_d.aluout = em_q.aluout;
    mw_d.dmemload = rsp.dmemload;
    mw_d.wsel = em_q.wsel;
    mw_d.memtoreg = em_q.memrd;
    mw_d.regwr = em_q.regwr;
    mw_d.halt = em_q.halt;
  end

  // writeback select
  assign wb_wdat = mw_q.memtoreg ? mw_q.dmemload : mw_q.aluout;
  assign wb_regwr = mw_q.valid && mw_q.regwr;

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      pc <= `CPU_PC_INIT;
      fd_q <= '0;
      de_q <= '0;
      em_q <= '0;
      mw_q <= '0;
    end
    else if (!mem_wait)
    begin
      em_q <= em_d;
      mw_q <= mw_d;
      // taken beq kills the two younger slots
      if (flush)
      begin
        pc <= branch_target;
        fd_q <= '0;
        de_q <= '0;
      end
      // load-use, hold pc and fd, bubble into execute
      else if (stall)
      begin
        de_q <= '0;
      end
      else
      begin
        fd_q <= fd_d;
        de_q <= de_d;
        if (fetch_ok)
        begin
          pc <= pc + 4;
        end
      end
    end
  end

  // halt one cycle after HALT reaches writeback, held until reset
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      halt <= 1'b0;
    end
    else if (mw_q.valid && mw_q.halt)
    begin
      halt <= 1'b1;
    end
  end

  // read and write requests are exclusive
  a_one_access: assert property (@(posedge CLK) disable iff (!nRST)
    !(req.dmemREN && req.dmemWEN))
    else $error("dmemREN and dmemWEN high together");

  // address held across the wait
  a_addr_held: assert property (@(posedge CLK) disable iff (!nRST)
    mem_wait |=> $stable(req.dmemaddr))
    else $error("dmemaddr moved while waiting for dhit");

endmodule

//--- tests/cache_model.sv
// instruction and data memories with hit delays drawn from an lcg
`timescale 1ns/1ps

module cache_model (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      random_en,
  input  cpu_types_pkg::dp_req_t    req,
  output cpu_types_pkg::cache_rsp_t rsp
);
  // word addressed, 1 KiB each
  cpu_types_pkg::word_t imem [256];
  cpu_types_pkg::word_t dmem [256];
  logic [31:0] lcg_state;
  logic [1:0]  i_wait;
  logic [1:0]  d_wait;
  logic        d_access;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  assign d_access = req.dmemREN || req.dmemWEN;

  // hit once the remaining delay reaches zero
  always_comb
  begin
    rsp.ihit = (i_wait == 2'd0);
    rsp.imemload = imem[req.imemaddr[9:2]];
    rsp.dhit = d_access && (d_wait == 2'd0);
    rsp.dmemload = dmem[req.dmemaddr[9:2]];
  end

  // generator steps every cycle
  // new delay drawn after each hit, 0 to 3 cycles
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      lcg_state <= 32'h7bfddde2;
      i_wait <= 2'd0;
      d_wait <= 2'd0;
    end
    else
    begin
      lcg_state <= lcg_next(lcg_state);
      if (i_wait != 2'd0)
        i_wait <= i_wait - 2'd1;
      else if (random_en)
        i_wait <= lcg_state[17:16];
      if (d_access)
      begin
        if (d_wait != 2'd0)
          d_wait <= d_wait - 2'd1;
        else if (random_en)
          d_wait <= lcg_state[25:24];
      end
    end
  end

  // store lands on the hit cycle
  always @(posedge CLK)
  begin
    if (req.dmemWEN && rsp.dhit)
      dmem[req.dmemaddr[9:2]] <= req.dmemstore;
  end

endmodule

//--- tests/tb_datapath.sv
// datapath testbench: clock, reset, program loading, directed tests, checks, summary
`timescale 1ns/1ps

module tb_datapath;
  logic CLK;
  logic nRST;
  logic random_en;
  logic halt;
  cpu_types_pkg::dp_req_t    req;
  cpu_types_pkg::cache_rsp_t rsp;
  // program under construction
  cpu_types_pkg::word_t prog [$];
  int errors;
  int pass_count;
  int fail_count;

  datapath dut0 (
    .CLK  (CLK),
    .nRST (nRST),
    .rsp  (rsp),
    .req  (req),
    .halt (halt)
  );

  cache_model cache0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .random_en (random_en),
    .req       (req),
    .rsp       (rsp)
  );

  // 8 ns period
  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  function automatic cpu_types_pkg::word_t enc_r(
    cpu_types_pkg::funct_e  f,
    cpu_types_pkg::regsel_t rd,
    cpu_types_pkg::regsel_t rs,
    cpu_types_pkg::regsel_t rt
  );
    cpu_types_pkg::instr_t w;
    w.r.opcode = cpu_types_pkg::RTYPE;
    w.r.rs = rs;
    w.r.rt = rt;
    w.r.rd = rd;
    w.r.shamt = 5'd0;
    w.r.funct = f;
    return w;
  endfunction

  function automatic cpu_types_pkg::word_t enc_i(
    cpu_types_pkg::opcode_e op,
    cpu_types_pkg::regsel_t rt,
    cpu_types_pkg::regsel_t rs,
    logic [15:0]            imm
  );
    cpu_types_pkg::instr_t w;
    w.i.opcode = op;
    w.i.rs = rs;
    w.i.rt = rt;
    w.i.imm = imm;
    return w;
  endfunction

  // cleared data word, unique per index
  function automatic cpu_types_pkg::word_t cleared_word(int idx);
    return 32'h5a5a_0000 ^ idx;
  endfunction

  function automatic cpu_types_pkg::word_t dmem_at(cpu_types_pkg::word_t addr);
    return cache0.dmem[addr[9:2]];
  endfunction

  task automatic emit(input cpu_types_pkg::word_t w);
    prog.push_back(w);
  endtask

  // tail of imem holds HALTs tagged with their index
  task automatic load_program;
    for (int i = 0; i < 256; i++)
    begin
      if (i < prog.size())
        cache0.imem[i] = prog[i];
      else
        cache0.imem[i] = enc_i(cpu_types_pkg::HALT, 0, 0, 16'(i));
      cache0.dmem[i] = cleared_word(i);
    end
    prog.delete();
  endtask

  task automatic run_reset(input logic rand_mode);
    @(posedge CLK);
    nRST <= 1'b0;
    random_en <= rand_mode;
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;
  endtask

  task automatic wait_halt(input string name);
    int cycles;
    cycles = 0;
    while (halt !== 1'b1 && cycles < 500)
    begin
      @(negedge CLK);
      cycles++;
    end
    if (halt !== 1'b1)
    begin
      $display("%s: no halt after %0d cycles, program did not finish", name, cycles);
      errors++;
    end
  endtask

  task automatic check_word(
    input string                name,
    input cpu_types_pkg::word_t exp,
    input cpu_types_pkg::word_t act
  );
    if (act !== exp)
    begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("mismatch %s expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int start);
    if (errors == start)
    begin
      $display("test %s: ok", name);
      pass_count++;
    end
    else
    begin
      $display("test %s: failed with %0d errors", name, errors - start);
      fail_count++;
    end
  endtask

  task automatic test_reset;
    int start;
    start = errors;
    emit(enc_i(cpu_types_pkg::HALT, 0, 0, 16'h0));
    load_program();
    run_reset(1'b0);
    // first stable point after release
    @(negedge CLK);
    check_bit("reset dmemREN", 1'b0, req.dmemREN);
    check_bit("reset dmemWEN", 1'b0, req.dmemWEN);
    check_bit("reset halt", 1'b0, halt);
    finish_test("reset", start);
  endtask

  // each op reads the result just before it
  task automatic test_forwarding(input string name, input logic rand_mode);
    cpu_types_pkg::word_t r [8];
    int start;
    start = errors;
    emit(enc_i(cpu_types_pkg::ADDIU, 1, 0, 16'd7));
    emit(enc_i(cpu_types_pkg::ADDIU, 2, 1, 16'd5));
    emit(enc_r(cpu_types_pkg::ADDU, 3, 2, 1));
    emit(enc_r(cpu_types_pkg::SUBU, 4, 2, 3));
    emit(enc_r(cpu_types_pkg::AND, 5, 4, 3));
    emit(enc_r(cpu_types_pkg::OR, 6, 5, 4));
    emit(enc_r(cpu_types_pkg::SLT, 7, 6, 3));
    for (int k = 1; k < 8; k++)
      emit(enc_i(cpu_types_pkg::SW, k, 0, 16'(32'h40 + 4 * (k - 1))));
    emit(enc_i(cpu_types_pkg::HALT, 0, 0, 16'h0));
    load_program();
    // sequential semantics
    r[0] = 32'd0;
    r[1] = 32'd7;
    r[2] = r[1] + 32'd5;
    r[3] = r[2] + r[1];
    r[4] = r[2] - r[3];
    r[5] = r[4] & r[3];
    r[6] = r[5] | r[4];
    // signed compare, r6 is negative
    r[7] = ($signed(r[6]) < $signed(r[3])) ? 32'd1 : 32'd0;
    run_reset(rand_mode);
    wait_halt(name);
    for (int k = 1; k < 8; k++)
      check_word($sformatf("%s r%0d", name, k), r[k], dmem_at(32'h40 + 4 * (k - 1)));
    finish_test(name, start);
  endtask

  task automatic test_load_use;
    cpu_types_pkg::word_t a;
    cpu_types_pkg::word_t sum;
    int start;
    start = errors;
    a = 32'h33;
    sum = a + a;
    emit(enc_i(cpu_types_pkg::ADDIU, 1, 0, 16'h33));
    emit(enc_i(cpu_types_pkg::SW, 1, 0, 16'h80));
    emit(enc_i(cpu_types_pkg::LW, 2, 0, 16'h80));
    // use right behind the load
    emit(enc_r(cpu_types_pkg::ADDU, 3, 2, 1));
    emit(enc_i(cpu_types_pkg::SW, 3, 0, 16'h84));
    emit(enc_i(cpu_types_pkg::LW, 4, 0, 16'h84));
    // loaded value as store data
    emit(enc_i(cpu_types_pkg::SW, 4, 0, 16'h88));
    emit(enc_i(cpu_types_pkg::HALT, 0, 0, 16'h0));
    load_program();
    run_reset(1'b0);
    wait_halt("load use");
    check_word("load use sum", sum, dmem_at(32'h84));
    check_word("load use store data", sum, dmem_at(32'h88));
    finish_test("load use", start);
  endtask

  task automatic test_branch;
    cpu_types_pkg::word_t exp3;
    cpu_types_pkg::word_t exp4;
    int start;
    start = errors;
    emit(enc_i(cpu_types_pkg::ADDIU, 1, 0, 16'd5));
    emit(enc_i(cpu_types_pkg::ADDIU, 2, 0, 16'd5));
    emit(enc_i(cpu_types_pkg::ADDIU, 3, 0, 16'd1));
    // 5 == 5, skips two
    emit(enc_i(cpu_types_pkg::BEQ, 2, 1, 16'd2));
    emit(enc_i(cpu_types_pkg::ADDIU, 3, 3, 16'd10));
    emit(enc_i(cpu_types_pkg::ADDIU, 3, 3, 16'd100));
    emit(enc_i(cpu_types_pkg::SW, 3, 0, 16'hc0));
    emit(enc_i(cpu_types_pkg::ADDIU, 4, 0, 16'd2));
    // 5 != 2, falls through
    emit(enc_i(cpu_types_pkg::BEQ, 4, 1, 16'd2));
    emit(enc_i(cpu_types_pkg::ADDIU, 4, 4, 16'd10));
    emit(enc_i(cpu_types_pkg::ADDIU, 4, 4, 16'd100));
    emit(enc_i(cpu_types_pkg::SW, 4, 0, 16'hc4));
    emit(enc_i(cpu_types_pkg::HALT, 0, 0, 16'h0));
    load_program();
    exp3 = 32'd1;
    if (32'd5 != 32'd5)
      exp3 = exp3 + 32'd110;
    exp4 = 32'd2;
    if (32'd5 != 32'd2)
      exp4 = exp4 + 32'd110;
    run_reset(1'b0);
    wait_halt("branch");
    check_word("branch taken", exp3, dmem_at(32'hc0));
    check_word("branch not taken", exp4, dmem_at(32'hc4));
    finish_test("branch", start);
  endtask

  task automatic test_halt;
    int start;
    start = errors;
    emit(enc_i(cpu_types_pkg::ADDIU, 1, 0, 16'h2a));
    emit(enc_i(cpu_types_pkg::SW, 1, 0, 16'h100));
    emit(enc_i(cpu_types_pkg::HALT, 0, 0, 16'h0));
    // must never reach memory
    emit(enc_i(cpu_types_pkg::SW, 1, 0, 16'h104));
    load_program();
    run_reset(1'b0);
    wait_halt("halt");
    // halt is sticky
    repeat (20) @(negedge CLK);
    check_bit("halt held", 1'b1, halt);
    check_word("halt store before", 32'h2a, dmem_at(32'h100));
    check_word("halt store after", cleared_word(32'h104 >> 2), dmem_at(32'h104));
    finish_test("halt", start);
  endtask

  initial
  begin
    nRST = 1'b0;
    random_en = 1'b0;
    errors = 0;
    pass_count = 0;
    fail_count = 0;
    test_reset();
    test_forwarding("forwarding", 1'b0);
    test_load_use();
    test_branch();
    test_forwarding("random delays", 1'b1);
    test_halt();
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
logic/cpu_types_pkg.sv
logic/register_file.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/forwarding_unit.sv
logic/hazard_unit.sv
logic/datapath.sv
tests/cache_model.sv
tests/tb_datapath.sv

//--- run.sh
#!/bin/sh
# build and run the datapath testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_datapath -f vlog.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# verdict comes from the log only
if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  exit 0
fi
exit 1
